/* source/rv_isa_pkg.sv */
// rv64i base and zicsr encodings used by the decode stage
`default_nettype none

package rv_isa_pkg;

	localparam int unsigned xlen = 64; // decode assumes rv64

	typedef logic [31:0]     inst_t;
	typedef logic [4:0]      reg_idx_t;
	typedef logic [xlen-1:0] xword_t;

	// major opcode, inst[6:0]
	typedef enum logic [6:0] {
		LOAD     = 7'b000_0011,
		OP_IMM   = 7'b001_0011,
		AUIPC    = 7'b001_0111,
		OP_IMM32 = 7'b001_1011, // addiw slliw srliw sraiw
		STORE    = 7'b010_0011,
		OP       = 7'b011_0011,
		LUI      = 7'b011_0111,
		OP32     = 7'b011_1011, // addw subw sllw srlw sraw
		BRANCH   = 7'b110_0011,
		JALR     = 7'b110_0111,
		JAL      = 7'b110_1111,
		SYSTEM   = 7'b111_0011
	} opcode_e;

	// branch compare
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// load width, bit 2 set means zero extend
	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LD  = 3'b011;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;
	localparam logic [2:0] F3_LWU = 3'b110;

	// store width
	localparam logic [2:0] F3_SB = 3'b000;
	localparam logic [2:0] F3_SH = 3'b001;
	localparam logic [2:0] F3_SW = 3'b010;
	localparam logic [2:0] F3_SD = 3'b011;

	// alu, shared by reg and imm forms
	localparam logic [2:0] F3_ADD_SUB = 3'b000; // inst[30] picks sub on reg form
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SR      = 3'b101; // inst[30] picks arithmetic
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// zicsr, bit 2 set means uimm in rs1 field
	localparam logic [2:0] F3_CSRRW  = 3'b001;
	localparam logic [2:0] F3_CSRRS  = 3'b010;
	localparam logic [2:0] F3_CSRRC  = 3'b011;
	localparam logic [2:0] F3_CSRRWI = 3'b101;
	localparam logic [2:0] F3_CSRRSI = 3'b110;
	localparam logic [2:0] F3_CSRRCI = 3'b111;

endpackage

`default_nettype wire

/* source/id_ctrl_pkg.sv */
// control encodings and the decoded bundle produced by the decode stage
`default_nettype none

package id_ctrl_pkg;

	// zero value is the idle op
	typedef enum logic [4:0] {
		ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLT,
		ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_IMM,
		ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE,
		ALU_BLTU, ALU_BGEU, ALU_ADDW, ALU_SUBW,
		ALU_SLLW, ALU_SRLW, ALU_SRAW
	} alu_op_e;

	typedef enum logic {OP1_REG, OP1_PC} op1_src_e;

	typedef enum logic [1:0] {OP2_REG, OP2_IMM, OP2_FOUR} op2_src_e; // four for link addr

	typedef enum logic [1:0] {CSR_NONE, CSR_RW, CSR_RS, CSR_RC} csr_op_e; // = funct3[1:0]

	// one flag per major opcode, all low for unknown
	typedef struct packed {
		logic op_imm;
		logic op_imm32;
		logic op;
		logic op32;
		logic lui;
		logic auipc;
		logic jal;
		logic jalr;
		logic branch;
		logic load;
		logic store;
		logic system;
	} opclass_t;

	typedef struct packed {
		logic                 rs1_r_ena;
		rv_isa_pkg::reg_idx_t rs1_r_addr;
		logic                 rs2_r_ena;
		rv_isa_pkg::reg_idx_t rs2_r_addr;
		logic                 rd_w_ena;
		rv_isa_pkg::reg_idx_t rd_w_addr;
		alu_op_e              alu_op;
		op1_src_e             alu_op1_src;
		op2_src_e             alu_op2_src;
		rv_isa_pkg::xword_t   imm;
		logic                 branch;
		logic                 jump;
		logic                 pc_src; // jalr target from rs1
		logic                 mem_r_ena;
		logic                 mem_w_ena;
		logic [7:0]           byte_enable;
		logic                 mem_ext_un;
		logic                 mem_to_reg;
		csr_op_e              csr_op;
		logic                 csr_rena;
		logic                 csr_wena;
	} id_bundle_t;

endpackage

`default_nettype wire

/* source/decode_if.sv */
// split instruction fields and opcode class, classifier to control decoders
`timescale 1ns/1ps
`default_nettype none

interface decode_if (
	input logic clk // only samples the decoder checks
);
	id_ctrl_pkg::opclass_t cls;
	logic [2:0]            funct3;
	logic                  alt; // inst[30]
	rv_isa_pkg::reg_idx_t  rd;
	rv_isa_pkg::reg_idx_t  rs1;
	rv_isa_pkg::reg_idx_t  rs2;
	rv_isa_pkg::inst_t     inst; // raw word for immediates

	modport producer (
		input  clk,
		output cls, funct3, alt, rd, rs1, rs2, inst
	);

	modport consumer (
		input clk,
		input cls, funct3, alt, rd, rs1, rs2, inst
	);
endinterface

`default_nettype wire

/* source/pipe_stage.sv */
// single entry valid/ready pipeline slot carrying any payload type
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	// free when empty or draining this cycle
	assign in_ready = ~out_valid | out_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			out_data  <= '0; // empty slot shows zero payload
		end else if (in_ready) begin
			out_valid <= in_valid;
			if (in_valid) begin
				out_data <= in_data;
			end
		end
	end

	// stalled output must not move
	a_hold_on_stall: assert property (
		@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data)
	);

endmodule

`default_nettype wire

/* source/inst_classify.sv */
// splits the instruction word into fields and flags its opcode class
`timescale 1ns/1ps
`default_nettype none

module inst_classify (
	input rv_isa_pkg::inst_t inst,
	decode_if.producer       dec
);

	logic [6:0] opcode;

	assign opcode = inst[6:0];

	assign dec.rd     = inst[11:7];
	assign dec.funct3 = inst[14:12];
	assign dec.rs1    = inst[19:15];
	assign dec.rs2    = inst[24:20];
	assign dec.alt    = inst[30]; // sub / sra select
	assign dec.inst   = inst;

	// exact match only, anything else leaves cls all zero
	assign dec.cls = '{
		op_imm:   opcode == rv_isa_pkg::OP_IMM,
		op_imm32: opcode == rv_isa_pkg::OP_IMM32,
		op:       opcode == rv_isa_pkg::OP,
		op32:     opcode == rv_isa_pkg::OP32,
		lui:      opcode == rv_isa_pkg::LUI,
		auipc:    opcode == rv_isa_pkg::AUIPC,
		jal:      opcode == rv_isa_pkg::JAL,
		jalr:     opcode == rv_isa_pkg::JALR,
		branch:   opcode == rv_isa_pkg::BRANCH,
		load:     opcode == rv_isa_pkg::LOAD,
		store:    opcode == rv_isa_pkg::STORE,
		system:   opcode == rv_isa_pkg::SYSTEM
	};

	// downstream decoders rely on a single class
	a_cls_onehot0: assert property (@(posedge dec.clk) $onehot0(dec.cls));

endmodule

`default_nettype wire

/* source/imm_gen.sv */
// builds the sign extended immediate for the instruction format in use
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
	decode_if.consumer          dec,
	output rv_isa_pkg::xword_t  imm
);

	rv_isa_pkg::inst_t  i;
	rv_isa_pkg::xword_t imm_i;
	rv_isa_pkg::xword_t imm_s;
	rv_isa_pkg::xword_t imm_b;
	rv_isa_pkg::xword_t imm_u;
	rv_isa_pkg::xword_t imm_j;

	assign i = dec.inst;

	// all formats extend from bit 31
	assign imm_i = {{52{i[31]}}, i[31:20]};
	assign imm_s = {{52{i[31]}}, i[31:25], i[11:7]};
	assign imm_b = {{52{i[31]}}, i[7], i[30:25], i[11:8], 1'b0}; // halfword aligned
	assign imm_u = {{32{i[31]}}, i[31:12], 12'b0};
	assign imm_j = {{44{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};

	always_comb begin
		imm = '0; // unknown class
		if (dec.cls.lui || dec.cls.auipc) begin
			imm = imm_u;
		end else if (dec.cls.jal) begin
			imm = imm_j;
		end else if (dec.cls.branch) begin
			imm = imm_b;
		end else if (dec.cls.store) begin
			imm = imm_s;
		end else if (dec.cls.jalr || dec.cls.load || dec.cls.op_imm ||
				dec.cls.op_imm32 || dec.cls.system) begin
			imm = imm_i; // system reuses it as csr address
		end
	end

endmodule

`default_nettype wire

/* source/alu_ctrl_decode.sv */
// alu operation, operand sources and branch / jump controls
`timescale 1ns/1ps
`default_nettype none

module alu_ctrl_decode (
	decode_if.consumer             dec,
	output id_ctrl_pkg::alu_op_e   alu_op,
	output id_ctrl_pkg::op1_src_e  alu_op1_src,
	output id_ctrl_pkg::op2_src_e  alu_op2_src,
	output logic                   branch,
	output logic                   jump,
	output logic                   pc_src
);

	id_ctrl_pkg::opclass_t c;

	assign c = dec.cls;

	always_comb begin
		alu_op = id_ctrl_pkg::ALU_NONE;
		if (c.op || c.op_imm) begin
			case (dec.funct3)
				rv_isa_pkg::F3_ADD_SUB: alu_op = (c.op && dec.alt) ? id_ctrl_pkg::ALU_SUB
					: id_ctrl_pkg::ALU_ADD; // no subi
				rv_isa_pkg::F3_SLL:  alu_op = id_ctrl_pkg::ALU_SLL;
				rv_isa_pkg::F3_SLT:  alu_op = id_ctrl_pkg::ALU_SLT;
				rv_isa_pkg::F3_SLTU: alu_op = id_ctrl_pkg::ALU_SLTU;
				rv_isa_pkg::F3_XOR:  alu_op = id_ctrl_pkg::ALU_XOR;
				rv_isa_pkg::F3_SR:   alu_op = dec.alt ? id_ctrl_pkg::ALU_SRA
					: id_ctrl_pkg::ALU_SRL;
				rv_isa_pkg::F3_OR:   alu_op = id_ctrl_pkg::ALU_OR;
				rv_isa_pkg::F3_AND:  alu_op = id_ctrl_pkg::ALU_AND;
				default:             alu_op = id_ctrl_pkg::ALU_NONE;
			endcase
		end else if (c.op32 || c.op_imm32) begin
			// word ops, only add/sub and shifts exist
			case (dec.funct3)
				rv_isa_pkg::F3_ADD_SUB: alu_op = (c.op32 && dec.alt) ? id_ctrl_pkg::ALU_SUBW
					: id_ctrl_pkg::ALU_ADDW;
				rv_isa_pkg::F3_SLL: alu_op = id_ctrl_pkg::ALU_SLLW;
				rv_isa_pkg::F3_SR:  alu_op = dec.alt ? id_ctrl_pkg::ALU_SRAW
					: id_ctrl_pkg::ALU_SRLW;
				default:            alu_op = id_ctrl_pkg::ALU_NONE;
			endcase
		end else if (c.branch) begin
			case (dec.funct3)
				rv_isa_pkg::F3_BEQ:  alu_op = id_ctrl_pkg::ALU_BEQ;
				rv_isa_pkg::F3_BNE:  alu_op = id_ctrl_pkg::ALU_BNE;
				rv_isa_pkg::F3_BLT:  alu_op = id_ctrl_pkg::ALU_BLT;
				rv_isa_pkg::F3_BGE:  alu_op = id_ctrl_pkg::ALU_BGE;
				rv_isa_pkg::F3_BLTU: alu_op = id_ctrl_pkg::ALU_BLTU;
				rv_isa_pkg::F3_BGEU: alu_op = id_ctrl_pkg::ALU_BGEU;
				default:             alu_op = id_ctrl_pkg::ALU_NONE;
			endcase
		end else if (c.load || c.store || c.auipc || c.jal || c.jalr) begin
			alu_op = id_ctrl_pkg::ALU_ADD; // address or link sum
		end else if (c.lui || c.system) begin
			alu_op = id_ctrl_pkg::ALU_PASS_IMM; // result is the immediate
		end
	end

	assign alu_op1_src = (c.auipc || c.jal || c.jalr) ? id_ctrl_pkg::OP1_PC
		: id_ctrl_pkg::OP1_REG;

	always_comb begin
		if (c.jal || c.jalr) begin
			alu_op2_src = id_ctrl_pkg::OP2_FOUR; // pc + 4 into rd
		end else if (c.lui || c.auipc || c.load || c.store || c.op_imm ||
				c.op_imm32 || c.system) begin
			alu_op2_src = id_ctrl_pkg::OP2_IMM;
		end else begin
			alu_op2_src = id_ctrl_pkg::OP2_REG; // op, op32, branch, unknown
		end
	end

	assign branch = c.branch;
	assign jump   = c.jal | c.jalr;
	assign pc_src = c.jalr; // 1 rs1 based, 0 pc based

endmodule

`default_nettype wire

/* source/lsu_ctrl_decode.sv */
// load / store enables, byte lanes and load extension
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl_decode (
	decode_if.consumer  dec,
	output logic        mem_r_ena,
	output logic        mem_w_ena,
	output logic        mem_to_reg,
	output logic        mem_ext_un,
	output logic [7:0]  byte_enable
);

	assign mem_r_ena  = dec.cls.load;
	assign mem_w_ena  = dec.cls.store;
	assign mem_to_reg = dec.cls.load; // wb takes load data

	// aligned access assumed, lanes start at byte 0
	always_comb begin
		byte_enable = 8'h00;
		mem_ext_un  = 1'b0;
		if (dec.cls.load) begin
			case (dec.funct3)
				rv_isa_pkg::F3_LB:  byte_enable = 8'h01;
				rv_isa_pkg::F3_LH:  byte_enable = 8'h03;
				rv_isa_pkg::F3_LW:  byte_enable = 8'h0f;
				rv_isa_pkg::F3_LD:  byte_enable = 8'hff;
				rv_isa_pkg::F3_LBU: begin
					byte_enable = 8'h01;
					mem_ext_un  = 1'b1;
				end
				rv_isa_pkg::F3_LHU: begin
					byte_enable = 8'h03;
					mem_ext_un  = 1'b1;
				end
				rv_isa_pkg::F3_LWU: begin
					byte_enable = 8'h0f;
					mem_ext_un  = 1'b1;
				end
				default: byte_enable = 8'h00; // funct3 111 reserved
			endcase
		end else if (dec.cls.store) begin
			case (dec.funct3)
				rv_isa_pkg::F3_SB: byte_enable = 8'h01;
				rv_isa_pkg::F3_SH: byte_enable = 8'h03;
				rv_isa_pkg::F3_SW: byte_enable = 8'h0f;
				rv_isa_pkg::F3_SD: byte_enable = 8'hff;
				default:           byte_enable = 8'h00;
			endcase
		end
	end

	// lanes never active without an access
	a_lanes_need_access: assert property (
		@(posedge dec.clk) (|byte_enable) |-> (mem_r_ena || mem_w_ena)
	);

endmodule

`default_nettype wire

/* source/reg_csr_decode.sv */
// register port enables and addresses plus zicsr operation and enables
`timescale 1ns/1ps
`default_nettype none

module reg_csr_decode (
	decode_if.consumer              dec,
	output logic                    rs1_r_ena,
	output rv_isa_pkg::reg_idx_t    rs1_r_addr,
	output logic                    rs2_r_ena,
	output rv_isa_pkg::reg_idx_t    rs2_r_addr,
	output logic                    rd_w_ena,
	output rv_isa_pkg::reg_idx_t    rd_w_addr,
	output id_ctrl_pkg::csr_op_e    csr_op,
	output logic                    csr_rena,
	output logic                    csr_wena
);

	id_ctrl_pkg::opclass_t c;
	logic rd_nz;
	logic rs1_nz; // also the uimm on i forms

	assign c      = dec.cls;
	assign rd_nz  = |dec.rd;
	assign rs1_nz = |dec.rs1;

	assign rs1_r_addr = dec.rs1;
	assign rs2_r_addr = dec.rs2;
	assign rd_w_addr  = dec.rd;

	assign rs2_r_ena = c.branch | c.store | c.op | c.op32;

	always_comb begin
		rs1_r_ena = c.jalr | c.branch | c.load | c.store | c.op | c.op32 |
			c.op_imm | c.op_imm32;
		rd_w_ena  = c.lui | c.auipc | c.jal | c.jalr | c.load | c.op | c.op32 |
			c.op_imm | c.op_imm32; // no rd on branch, store
		csr_op    = id_ctrl_pkg::CSR_NONE;
		csr_rena  = 1'b0;
		csr_wena  = 1'b0;
		if (c.system) begin
			csr_op = id_ctrl_pkg::csr_op_e'(dec.funct3[1:0]);
			case (dec.funct3)
				rv_isa_pkg::F3_CSRRW, rv_isa_pkg::F3_CSRRWI: begin
					csr_rena  = rd_nz; // skip the read side effect for rd x0
					csr_wena  = 1'b1;
					rs1_r_ena = ~dec.funct3[2];
					rd_w_ena  = rd_nz;
				end
				rv_isa_pkg::F3_CSRRS, rv_isa_pkg::F3_CSRRC,
				rv_isa_pkg::F3_CSRRSI, rv_isa_pkg::F3_CSRRCI: begin
					csr_rena  = 1'b1;
					csr_wena  = rs1_nz; // x0 / zero mask leaves csr untouched
					rs1_r_ena = ~dec.funct3[2] & rs1_nz;
					rd_w_ena  = 1'b1;
				end
				default: csr_op = id_ctrl_pkg::CSR_NONE; // ecall, ebreak, reserved
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/id_stage_top.sv */
// rv64i decode stage between two valid/ready slots
`timescale 1ns/1ps
`default_nettype none

module id_stage_top (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   in_valid,
	output logic                   in_ready,
	input  rv_isa_pkg::inst_t      inst,
	output logic                   out_valid,
	input  logic                   out_ready,
	output logic                   rs1_r_ena,
	output rv_isa_pkg::reg_idx_t   rs1_r_addr,
	output logic                   rs2_r_ena,
	output rv_isa_pkg::reg_idx_t   rs2_r_addr,
	output logic                   rd_w_ena,
	output rv_isa_pkg::reg_idx_t   rd_w_addr,
	output id_ctrl_pkg::alu_op_e   alu_op,
	output id_ctrl_pkg::op1_src_e  alu_op1_src,
	output id_ctrl_pkg::op2_src_e  alu_op2_src,
	output rv_isa_pkg::xword_t     imm,
	output logic                   branch,
	output logic                   jump,
	output logic                   pc_src,
	output logic                   mem_r_ena,
	output logic                   mem_w_ena,
	output logic [7:0]             byte_enable,
	output logic                   mem_ext_un,
	output logic                   mem_to_reg,
	output id_ctrl_pkg::csr_op_e   csr_op,
	output logic                   csr_rena,
	output logic                   csr_wena
);

	rv_isa_pkg::inst_t       inst_q; // held instruction
	logic                    mid_valid;
	logic                    mid_ready;
	wire id_ctrl_pkg::id_bundle_t bundle_d; // each decoder drives its own fields
	id_ctrl_pkg::id_bundle_t bundle_q;

	decode_if dec_if (.clk(clk));

	pipe_stage #(.payload_t(rv_isa_pkg::inst_t)) i_in_slot (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (inst),
		.out_valid (mid_valid),
		.out_ready (mid_ready),
		.out_data  (inst_q)
	);

	inst_classify i_classify (
		.inst (inst_q),
		.dec  (dec_if.producer)
	);

	imm_gen i_imm_gen (
		.dec (dec_if.consumer),
		.imm (bundle_d.imm)
	);

	alu_ctrl_decode i_alu_ctrl (
		.dec         (dec_if.consumer),
		.alu_op      (bundle_d.alu_op),
		.alu_op1_src (bundle_d.alu_op1_src),
		.alu_op2_src (bundle_d.alu_op2_src),
		.branch      (bundle_d.branch),
		.jump        (bundle_d.jump),
		.pc_src      (bundle_d.pc_src)
	);

	lsu_ctrl_decode i_lsu_ctrl (
		.dec         (dec_if.consumer),
		.mem_r_ena   (bundle_d.mem_r_ena),
		.mem_w_ena   (bundle_d.mem_w_ena),
		.mem_to_reg  (bundle_d.mem_to_reg),
		.mem_ext_un  (bundle_d.mem_ext_un),
		.byte_enable (bundle_d.byte_enable)
	);

	reg_csr_decode i_reg_csr (
		.dec        (dec_if.consumer),
		.rs1_r_ena  (bundle_d.rs1_r_ena),
		.rs1_r_addr (bundle_d.rs1_r_addr),
		.rs2_r_ena  (bundle_d.rs2_r_ena),
		.rs2_r_addr (bundle_d.rs2_r_addr),
		.rd_w_ena   (bundle_d.rd_w_ena),
		.rd_w_addr  (bundle_d.rd_w_addr),
		.csr_op     (bundle_d.csr_op),
		.csr_rena   (bundle_d.csr_rena),
		.csr_wena   (bundle_d.csr_wena)
	);

	// second slot, registers the decoded bundle
	pipe_stage #(.payload_t(id_ctrl_pkg::id_bundle_t)) i_out_slot (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (mid_valid),
		.in_ready  (mid_ready),
		.in_data   (bundle_d),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (bundle_q)
	);

	assign rs1_r_ena   = bundle_q.rs1_r_ena;
	assign rs1_r_addr  = bundle_q.rs1_r_addr;
	assign rs2_r_ena   = bundle_q.rs2_r_ena;
	assign rs2_r_addr  = bundle_q.rs2_r_addr;
	assign rd_w_ena    = bundle_q.rd_w_ena;
	assign rd_w_addr   = bundle_q.rd_w_addr;
	assign alu_op      = bundle_q.alu_op;
	assign alu_op1_src = bundle_q.alu_op1_src;
	assign alu_op2_src = bundle_q.alu_op2_src;
	assign imm         = bundle_q.imm;
	assign branch      = bundle_q.branch;
	assign jump        = bundle_q.jump;
	assign pc_src      = bundle_q.pc_src;
	assign mem_r_ena   = bundle_q.mem_r_ena;
	assign mem_w_ena   = bundle_q.mem_w_ena;
	assign byte_enable = bundle_q.byte_enable;
	assign mem_ext_un  = bundle_q.mem_ext_un;
	assign mem_to_reg  = bundle_q.mem_to_reg;
	assign csr_op      = bundle_q.csr_op;
	assign csr_rena    = bundle_q.csr_rena;
	assign csr_wena    = bundle_q.csr_wena;

endmodule

`default_nettype wire

/* dv/tb_id_stage.sv */
// self-checking testbench for the rv64i decode stage against a reference decode
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

	localparam int n_rep     = 4; // random fills per encoding
	localparam int n_bp      = 64;
	localparam int n_lat     = 32;
	localparam int n_total   = (36 + 16 + 12) * n_rep + 24 + n_bp + n_lat;
	localparam int wd_cycles = n_total * 20 + 200; // plus reset and drains

	logic                    clk = 1'b0;
	logic                    arst_n;
	logic                    in_valid;
	logic                    in_ready;
	rv_isa_pkg::inst_t       inst;
	logic                    out_valid;
	logic                    out_ready;
	wire id_ctrl_pkg::id_bundle_t got_b; // dut outputs regrouped

	id_ctrl_pkg::id_bundle_t exp_b = '0; // decode of oldest pending instruction
	rv_isa_pkg::inst_t       sent_q[$];
	int                      q_len   = 0;
	int                      in_cnt  = 0;
	int                      out_cnt = 0;
	int                      err_cnt = 0;
	int                      err_at_start;
	int                      n_pass  = 0;
	int                      n_bad   = 0;
	string                   test_name = "reset";
	logic [15:0]             lfsr_q  = 16'd59;
	logic                    took; // handshake seen at the last edge
	logic                    bp_mode  = 1'b0; // out_ready from the lfsr
	logic                    idle_chk = 1'b0;
	logic                    lat_chk  = 1'b0;

	logic [6:0] alu_opcs [4]  = '{rv_isa_pkg::OP, rv_isa_pkg::OP_IMM,
		rv_isa_pkg::OP32, rv_isa_pkg::OP_IMM32};
	logic [6:0] bad_opcs [4]  = '{7'h00, 7'h7f, 7'h0f, 7'h53}; // fence, op-fp not decoded
	logic [6:0] flow_opcs [4] = '{rv_isa_pkg::JAL, rv_isa_pkg::JALR,
		rv_isa_pkg::LUI, rv_isa_pkg::AUIPC};
	logic [6:0] all_opcs [12] = '{rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_IMM32, rv_isa_pkg::OP,
		rv_isa_pkg::OP32, rv_isa_pkg::LUI, rv_isa_pkg::AUIPC, rv_isa_pkg::JAL,
		rv_isa_pkg::JALR, rv_isa_pkg::BRANCH, rv_isa_pkg::LOAD, rv_isa_pkg::STORE,
		rv_isa_pkg::SYSTEM};
	logic [2:0] csr_f3s [6]   = '{3'b001, 3'b010, 3'b011, 3'b101, 3'b110, 3'b111};

	always #5 clk = ~clk;

	id_stage_top i_dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.inst        (inst),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.rs1_r_ena   (got_b.rs1_r_ena),
		.rs1_r_addr  (got_b.rs1_r_addr),
		.rs2_r_ena   (got_b.rs2_r_ena),
		.rs2_r_addr  (got_b.rs2_r_addr),
		.rd_w_ena    (got_b.rd_w_ena),
		.rd_w_addr   (got_b.rd_w_addr),
		.alu_op      (got_b.alu_op),
		.alu_op1_src (got_b.alu_op1_src),
		.alu_op2_src (got_b.alu_op2_src),
		.imm         (got_b.imm),
		.branch      (got_b.branch),
		.jump        (got_b.jump),
		.pc_src      (got_b.pc_src),
		.mem_r_ena   (got_b.mem_r_ena),
		.mem_w_ena   (got_b.mem_w_ena),
		.byte_enable (got_b.byte_enable),
		.mem_ext_un  (got_b.mem_ext_un),
		.mem_to_reg  (got_b.mem_to_reg),
		.csr_op      (got_b.csr_op),
		.csr_rena    (got_b.csr_rena),
		.csr_wena    (got_b.csr_wena)
	);

	// x^16 + x^14 + x^13 + x^11 lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		int          k;
		r = '0;
		for (k = 0; k < n; k++) begin
			lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
			r      = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	// alu op for op and op-imm where sub exists only on the reg form
	function automatic id_ctrl_pkg::alu_op_e int_alu_op(input logic [2:0] f3,
			input logic sub, input logic arith);
		case (f3)
			3'b000:  return sub ? id_ctrl_pkg::ALU_SUB : id_ctrl_pkg::ALU_ADD;
			3'b001:  return id_ctrl_pkg::ALU_SLL;
			3'b010:  return id_ctrl_pkg::ALU_SLT;
			3'b011:  return id_ctrl_pkg::ALU_SLTU;
			3'b100:  return id_ctrl_pkg::ALU_XOR;
			3'b101:  return arith ? id_ctrl_pkg::ALU_SRA : id_ctrl_pkg::ALU_SRL;
			3'b110:  return id_ctrl_pkg::ALU_OR;
			default: return id_ctrl_pkg::ALU_AND;
		endcase
	endfunction

	function automatic id_ctrl_pkg::alu_op_e word_alu_op(input logic [2:0] f3,
			input logic sub, input logic arith);
		case (f3)
			3'b000:  return sub ? id_ctrl_pkg::ALU_SUBW : id_ctrl_pkg::ALU_ADDW;
			3'b001:  return id_ctrl_pkg::ALU_SLLW;
			3'b101:  return arith ? id_ctrl_pkg::ALU_SRAW : id_ctrl_pkg::ALU_SRLW;
			default: return id_ctrl_pkg::ALU_NONE; // no other word ops
		endcase
	endfunction

	function automatic id_ctrl_pkg::alu_op_e branch_cmp_op(input logic [2:0] f3);
		case (f3)
			3'b000:  return id_ctrl_pkg::ALU_BEQ;
			3'b001:  return id_ctrl_pkg::ALU_BNE;
			3'b100:  return id_ctrl_pkg::ALU_BLT;
			3'b101:  return id_ctrl_pkg::ALU_BGE;
			3'b110:  return id_ctrl_pkg::ALU_BLTU;
			3'b111:  return id_ctrl_pkg::ALU_BGEU;
			default: return id_ctrl_pkg::ALU_NONE;
		endcase
	endfunction

	function automatic logic [7:0] lane_mask(input logic [1:0] size);
		return (size == 2'd0) ? 8'h01 : (size == 2'd1) ? 8'h03 : (size == 2'd2) ? 8'h0f : 8'hff;
	endfunction

	// expected decode straight from the isa rules
	function automatic id_ctrl_pkg::id_bundle_t ref_decode(input rv_isa_pkg::inst_t w);
		id_ctrl_pkg::id_bundle_t b;
		logic [2:0]              f3;
		logic [63:0]             imm_i;
		b      = '0;
		f3     = w[14:12];
		imm_i  = {{52{w[31]}}, w[31:20]};
		b.rs1_r_addr = w[19:15];
		b.rs2_r_addr = w[24:20];
		b.rd_w_addr  = w[11:7];
		case (w[6:0])
			rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_IMM32: begin
				b.alu_op = (w[3]) ? word_alu_op(f3, 1'b0, w[30]) : int_alu_op(f3, 1'b0, w[30]);
				b.alu_op2_src = id_ctrl_pkg::OP2_IMM;
				b.imm         = imm_i;
				b.rs1_r_ena   = 1'b1;
				b.rd_w_ena    = 1'b1;
			end
			rv_isa_pkg::OP, rv_isa_pkg::OP32: begin
				b.alu_op = (w[3]) ? word_alu_op(f3, w[30], w[30]) : int_alu_op(f3, w[30], w[30]);
				b.rs1_r_ena = 1'b1; // op2 stays reg
				b.rs2_r_ena = 1'b1;
				b.rd_w_ena  = 1'b1;
			end
			rv_isa_pkg::LUI, rv_isa_pkg::AUIPC: begin
				b.alu_op      = w[5] ? id_ctrl_pkg::ALU_PASS_IMM : id_ctrl_pkg::ALU_ADD;
				b.alu_op1_src = w[5] ? id_ctrl_pkg::OP1_REG : id_ctrl_pkg::OP1_PC;
				b.alu_op2_src = id_ctrl_pkg::OP2_IMM;
				b.imm         = {{32{w[31]}}, w[31:12], 12'h000};
				b.rd_w_ena    = 1'b1;
			end
			rv_isa_pkg::JAL, rv_isa_pkg::JALR: begin
				b.alu_op      = id_ctrl_pkg::ALU_ADD;
				b.alu_op1_src = id_ctrl_pkg::OP1_PC;
				b.alu_op2_src = id_ctrl_pkg::OP2_FOUR; // link address
				b.imm         = w[3] ? {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0} : imm_i;
				b.jump        = 1'b1;
				b.pc_src      = ~w[3];
				b.rs1_r_ena   = ~w[3];
				b.rd_w_ena    = 1'b1;
			end
			rv_isa_pkg::BRANCH: begin
				b.alu_op    = branch_cmp_op(f3);
				b.imm       = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
				b.branch    = 1'b1;
				b.rs1_r_ena = 1'b1;
				b.rs2_r_ena = 1'b1;
			end
			rv_isa_pkg::LOAD: begin
				b.alu_op      = id_ctrl_pkg::ALU_ADD;
				b.alu_op2_src = id_ctrl_pkg::OP2_IMM;
				b.imm         = imm_i;
				b.rs1_r_ena   = 1'b1;
				b.rd_w_ena    = 1'b1;
				b.mem_r_ena   = 1'b1;
				b.mem_to_reg  = 1'b1;
				b.byte_enable = (f3 == 3'b111) ? 8'h00 : lane_mask(f3[1:0]); // 111 reserved
				b.mem_ext_un  = f3[2] && f3 != 3'b111;
			end
			rv_isa_pkg::STORE: begin
				b.alu_op      = id_ctrl_pkg::ALU_ADD;
				b.alu_op2_src = id_ctrl_pkg::OP2_IMM;
				b.imm         = {{52{w[31]}}, w[31:25], w[11:7]};
				b.rs1_r_ena   = 1'b1;
				b.rs2_r_ena   = 1'b1;
				b.mem_w_ena   = 1'b1;
				b.byte_enable = f3[2] ? 8'h00 : lane_mask(f3[1:0]);
			end
			rv_isa_pkg::SYSTEM: begin
				b.alu_op      = id_ctrl_pkg::ALU_PASS_IMM;
				b.alu_op2_src = id_ctrl_pkg::OP2_IMM;
				b.imm         = imm_i;
				b.csr_op      = id_ctrl_pkg::csr_op_e'(f3[1:0]);
				if (f3[1:0] == 2'b01) begin
					b.csr_rena  = |w[11:7];
					b.csr_wena  = 1'b1;
					b.rs1_r_ena = ~f3[2];
					b.rd_w_ena  = |w[11:7];
				end else if (f3[1:0] != 2'b00) begin
					b.csr_rena  = 1'b1;
					b.csr_wena  = |w[19:15]; // zero mask writes nothing
					b.rs1_r_ena = ~f3[2] & (|w[19:15]);
					b.rd_w_ena  = 1'b1;
				end
			end
			default: ; // unknown opcode passes only the addresses
		endcase
		return b;
	endfunction

	function automatic rv_isa_pkg::inst_t make_inst(input logic [6:0] opc, input logic [2:0] f3);
		logic [16:0] hi;
		logic [4:0]  rd;
		hi = 17'(rand_bits(17));
		rd = 5'(rand_bits(5));
		return {hi, f3, rd, opc};
	endfunction

	function automatic rv_isa_pkg::inst_t csr_inst(input logic [2:0] f3, input logic [4:0] rd,
			input logic [4:0] rs1);
		logic [11:0] csr;
		csr = 12'(rand_bits(12));
		return {csr, rs1, f3, rd, rv_isa_pkg::SYSTEM};
	endfunction

	// scoreboard pushes on accept and pops on output transfer
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sent_q.delete();
			q_len = 0;
			exp_b = '0;
		end else begin
			if (out_valid && out_ready) begin
				out_cnt++; // every dut output transfer
				if (sent_q.size() > 0) begin
					void'(sent_q.pop_front());
				end
			end
			if (in_valid && in_ready) begin
				sent_q.push_back(inst);
				in_cnt++;
			end
			q_len = sent_q.size();
			exp_b = (q_len > 0) ? ref_decode(sent_q[0]) : '0;
		end
	end

	a_idle_handshake: assert property (@(posedge clk) idle_chk |-> !out_valid && in_ready)
	else begin
		$display("%s: slot not empty or not ready after reset", test_name);
		err_cnt++;
	end

	a_idle_zero: assert property (@(posedge clk) idle_chk |-> got_b == '0)
	else begin
		$display("Mismatch %s: expected %h actual %h", test_name,
			id_ctrl_pkg::id_bundle_t'(0), $sampled(got_b));
		err_cnt++;
	end

	a_decode_match: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && out_ready |-> got_b == exp_b)
	else begin
		$display("Mismatch %s: expected %h actual %h", test_name,
			$sampled(exp_b), $sampled(got_b));
		err_cnt++;
	end

	a_no_extra: assert property (@(posedge clk) disable iff (!arst_n) out_valid |-> q_len > 0)
	else begin
		$display("%s: output valid with no instruction pending", test_name);
		err_cnt++;
	end

	// two cycles accept to output with out_ready high
	a_latency: assert property (@(posedge clk) disable iff (!arst_n)
		lat_chk && in_valid && in_ready |-> ##2 out_valid &&
		got_b.rd_w_addr == $past(inst[11:7], 2))
	else begin
		$display("%s: accepted instruction not on the output 2 cycles later", test_name);
		err_cnt++;
	end

	task automatic tick();
		@(posedge clk);
		took = in_valid && in_ready;
		#1; // drive point
		if (bp_mode) begin
			out_ready = 1'(rand_bits(1));
		end
	endtask

	task automatic send(input rv_isa_pkg::inst_t w);
		in_valid = 1'b1;
		inst     = w;
		tick();
		while (!took) begin
			tick();
		end
		in_valid = 1'b0;
	endtask

	task automatic drain();
		while (q_len != 0 || out_valid) begin
			tick();
		end
	endtask

	task automatic start_test(input string name);
		test_name    = name;
		err_at_start = err_cnt;
	endtask

	task automatic finish_test();
		if (err_cnt == err_at_start) begin
			$display("[PASS] %s", test_name);
			n_pass++;
		end else begin
			$display("[FAIL] %s, %0d errors", test_name, err_cnt - err_at_start);
			n_bad++;
		end
	endtask

	initial begin
		#(wd_cycles * 10);
		$display("timeout after %0d cycles, the stream stopped moving", wd_cycles);
		$display("Test failed");
		$finish;
	end

	initial begin
		int a;
		int f;
		int r;
		in_valid  = 1'b0;
		inst      = '0;
		out_ready = 1'b1;
		arst_n    = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;

		start_test("reset_idle");
		idle_chk = 1'b1;
		repeat (3) tick();
		idle_chk = 1'b0;
		finish_test();

		start_test("alu_ops");
		for (a = 0; a < 4; a++) begin
			for (f = 0; f < 8; f++) begin
				for (r = 0; r < n_rep; r++) begin
					send(make_inst(alu_opcs[a], 3'(f)));
				end
			end
			for (r = 0; r < n_rep; r++) begin
				send(make_inst(bad_opcs[a], 3'(rand_bits(3))));
			end
		end
		drain();
		finish_test();

		start_test("mem_ops");
		for (f = 0; f < 8; f++) begin
			for (r = 0; r < n_rep; r++) begin
				send(make_inst(rv_isa_pkg::LOAD, 3'(f)));
				send(make_inst(rv_isa_pkg::STORE, 3'(f)));
			end
		end
		drain();
		finish_test();

		start_test("ctrl_flow");
		for (f = 0; f < 8; f++) begin
			for (r = 0; r < n_rep; r++) begin
				send(make_inst(rv_isa_pkg::BRANCH, 3'(f)));
			end
		end
		for (a = 0; a < 4; a++) begin
			for (r = 0; r < n_rep; r++) begin
				send(make_inst(flow_opcs[a], 3'(rand_bits(3))));
			end
		end
		drain();
		finish_test();

		start_test("csr_ops");
		for (f = 0; f < 6; f++) begin
			for (a = 0; a < 4; a++) begin
				send(csr_inst(csr_f3s[f], a[0] ? 5'(rand_bits(5)) | 5'd1 : 5'd0,
					a[1] ? 5'(rand_bits(5)) | 5'd1 : 5'd0)); // zero and nonzero fields
			end
		end
		drain();
		finish_test();

		start_test("stream_backpressure");
		bp_mode = 1'b1;
		for (r = 0; r < n_bp; r++) begin
			send(make_inst(all_opcs[rand_bits(4) % 12], 3'(rand_bits(3))));
		end
		drain();
		bp_mode   = 1'b0;
		out_ready = 1'b1;
		assert (out_cnt == in_cnt) else begin
			$display("%s: %0d accepted but %0d delivered", test_name, in_cnt, out_cnt);
			err_cnt++;
		end
		finish_test();

		start_test("stream_latency");
		lat_chk = 1'b1;
		for (r = 0; r < n_lat; r++) begin
			send(make_inst(all_opcs[rand_bits(4) % 12], 3'(rand_bits(3))));
		end
		drain();
		lat_chk = 1'b0;
		finish_test();

		$display("tests passed %0d failed %0d, check errors %0d", n_pass, n_bad, err_cnt);
		if (n_bad == 0 && err_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
source/rv_isa_pkg.sv
source/id_ctrl_pkg.sv
source/decode_if.sv
source/pipe_stage.sv
source/inst_classify.sv
source/imm_gen.sv
source/alu_ctrl_decode.sv
source/lsu_ctrl_decode.sv
source/reg_csr_decode.sv
source/id_stage_top.sv
dv/tb_id_stage.sv
